// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= soc_core_tb
RTL_TOP ?= soc_core
FILELIST ?= soc_core.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== bridge/periph_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_bridge (
	input logic clock,
	input logic i_rst_n,
	soc_bus_if.slave near,
	soc_bus_if.master far
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		BR_IDLE,
		BR_FAR,
		BR_REPLY
	} bridge_state_e;

	bridge_state_e state;
	logic rw_q;
	far_addr_t address_q;
	data_t wdata_q;
	data_t rdata_q;

	// ==================================================
	// Phase control
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			state <= BR_IDLE;
		end else begin
			case (state)
				BR_IDLE: begin
					if (near.request)
						state <= BR_FAR;
				end
				BR_FAR: begin
					if (far.ready)
						state <= BR_REPLY;
				end
				default: begin
					state <= BR_IDLE;
				end
			endcase
		end
	end

	// Latched access and its result
	always_ff @(posedge clock) begin
		if (state == BR_IDLE && near.request) begin
			rw_q <= near.rw;
			address_q <= near.address[27:0];
			wdata_q <= near.wdata;
		end
		if (state == BR_FAR && far.ready)
			rdata_q <= far.rdata;
	end

	assign far.request = (state == BR_FAR);
	assign far.rw = rw_q;
	assign far.address = {4'h0, address_q};
	assign far.wdata = wdata_q;

	assign near.rdata = rdata_q;
	assign near.ready = (state == BR_REPLY);

endmodule

`default_nettype wire

// ==== bridge/timer_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_block #(
	parameter int TIMER_PRESCALE = 4
) (
	input logic clock,
	input logic i_rst_n,
	soc_bus_if.slave bus,
	output logic o_irq
);
	import soc_pkg::*;

	localparam int PRE_W = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

	far_addr_t far_address;
	periph_t device;
	timer_reg_e reg_sel;
	logic hit;
	logic access;
	logic ready_q;
	data_t rdata_q;
	logic [PRE_W-1:0] prescale_cnt;
	data_t count;
	data_t compare;
	logic enable;

	assign far_address = bus.address[27:0];
	assign device = far_address[27:24];
	assign reg_sel = timer_reg_e'(far_address[3:2]);
	assign hit = (device == PERIPH_TIMER);
	assign access = bus.request && !ready_q;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
			prescale_cnt <= '0;
			count <= '0;
			compare <= '0;
			enable <= 1'b0;
		end else begin
			ready_q <= access;
			if (enable) begin
				if (prescale_cnt == PRE_W'(TIMER_PRESCALE - 1)) begin
					prescale_cnt <= '0;
					count <= count + 1'b1;
				end else begin
					prescale_cnt <= prescale_cnt + 1'b1;
				end
			end
			// Control write restarts the count
			if (access && hit && bus.rw) begin
				case (reg_sel)
					TIMER_COMPARE: compare <= bus.wdata;
					TIMER_CONTROL: begin
						enable <= bus.wdata[0];
						count <= '0;
						prescale_cnt <= '0;
					end
					default: ;
				endcase
			end
		end
	end

	// Other devices still get an answer, always zero
	always_ff @(posedge clock) begin
		if (access) begin
			rdata_q <= '0;
			if (hit) begin
				case (reg_sel)
					TIMER_COUNT: rdata_q <= count;
					TIMER_COMPARE: rdata_q <= compare;
					TIMER_CONTROL: rdata_q <= {31'b0, enable};
					default: rdata_q <= '0;
				endcase
			end
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.ready = ready_q;

	assign o_irq = enable && (count >= compare);

endmodule

`default_nettype wire

// ==== bus/addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
	input logic clock,
	input logic i_rst_n,
	soc_bus_if.slave host,
	soc_bus_if.master ram,
	soc_bus_if.master near
);
	import soc_pkg::*;

	region_t region;
	logic sel_ram;
	logic sel_bridge;
	logic unmapped_ready;

	assign region = host.address[31:28];
	assign sel_ram = (region == REGION_RAM);
	assign sel_bridge = (region == REGION_BRIDGE);

	// Targets see a region-relative address
	assign ram.request = host.request && sel_ram;
	assign ram.rw = host.rw;
	assign ram.address = {4'h0, host.address[27:0]};
	assign ram.wdata = host.wdata;

	assign near.request = host.request && sel_bridge;
	assign near.rw = host.rw;
	assign near.address = {4'h0, host.address[27:0]};
	assign near.wdata = host.wdata;

	// Nothing mapped here, answer with zero after one cycle
	always_ff @(posedge clock) begin
		if (!i_rst_n)
			unmapped_ready <= 1'b0;
		else
			unmapped_ready <= host.request && !sel_ram && !sel_bridge && !unmapped_ready;
	end

	assign host.rdata = sel_ram ? ram.rdata : sel_bridge ? near.rdata : '0;
	assign host.ready = sel_ram ? ram.ready : sel_bridge ? near.ready : unmapped_ready;

endmodule

`default_nettype wire

// ==== bus/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input logic clock,
	input logic i_rst_n,

	// Port A, instruction fetch
	input logic i_pa_request,
	input soc_pkg::addr_t i_pa_address,
	output soc_pkg::data_t o_pa_rdata,
	output logic o_pa_ready,

	// Port B, data
	input logic i_pb_request,
	input logic i_pb_rw,
	input soc_pkg::addr_t i_pb_address,
	input soc_pkg::data_t i_pb_wdata,
	output soc_pkg::data_t o_pb_rdata,
	output logic o_pb_ready,

	// Port C, DMA
	input logic i_pc_request,
	input logic i_pc_rw,
	input soc_pkg::addr_t i_pc_address,
	input soc_pkg::data_t i_pc_wdata,
	output soc_pkg::data_t o_pc_rdata,
	output logic o_pc_ready,

	soc_bus_if.master bus
);
	import soc_pkg::*;

	arb_state_e state;

	// Grant is locked until the slave answers
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			state <= ARB_IDLE;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (i_pc_request)
						state <= ARB_PORT_C;
					else if (i_pb_request)
						state <= ARB_PORT_B;
					else if (i_pa_request)
						state <= ARB_PORT_A;
				end
				default: begin
					if (bus.ready)
						state <= ARB_IDLE;
				end
			endcase
		end
	end

	always_comb begin
		bus.request = 1'b0;
		bus.rw = 1'b0;
		bus.address = '0;
		bus.wdata = '0;
		case (state)
			ARB_PORT_A: begin
				bus.request = 1'b1;
				bus.address = i_pa_address;
			end
			ARB_PORT_B: begin
				bus.request = 1'b1;
				bus.rw = i_pb_rw;
				bus.address = i_pb_address;
				bus.wdata = i_pb_wdata;
			end
			ARB_PORT_C: begin
				bus.request = 1'b1;
				bus.rw = i_pc_rw;
				bus.address = i_pc_address;
				bus.wdata = i_pc_wdata;
			end
			default: begin
				bus.request = 1'b0;
			end
		endcase
	end

	assign o_pa_rdata = bus.rdata;
	assign o_pb_rdata = bus.rdata;
	assign o_pc_rdata = bus.rdata;

	assign o_pa_ready = bus.ready && (state == ARB_PORT_A);
	assign o_pb_ready = bus.ready && (state == ARB_PORT_B);
	assign o_pc_ready = bus.ready && (state == ARB_PORT_C);

endmodule

`default_nettype wire

// ==== common/soc_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface soc_bus_if;
	import soc_pkg::*;

	logic request;
	logic rw;
	addr_t address;
	data_t wdata;
	data_t rdata;
	logic ready;

	modport master (
		output request, rw, address, wdata,
		input rdata, ready
	);

	modport slave (
		input request, rw, address, wdata,
		output rdata, ready
	);

endinterface

`default_nettype wire

// ==== common/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	// Bus widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [27:0] far_addr_t;

	// ==================================================
	// Memory map, top address nibble
	typedef logic [3:0] region_t;

	localparam region_t REGION_RAM    = 4'h1;
	localparam region_t REGION_BRIDGE = 4'h5;

	// Device nibble on the far side of the bridge
	typedef logic [3:0] periph_t;

	localparam periph_t PERIPH_TIMER = 4'h5;

	// Timer registers, word index from address bits 3:2
	typedef enum logic [1:0] {
		TIMER_COUNT   = 2'd0,
		TIMER_COMPARE = 2'd1,
		TIMER_CONTROL = 2'd2
	} timer_reg_e;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_PORT_A,
		ARB_PORT_B,
		ARB_PORT_C
	} arb_state_e;

endpackage

`default_nettype wire

// ==== sim/soc_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_core_tb;
	import soc_pkg::*;

	localparam int RAM_WORDS = 1024;
	localparam int TIMER_PRESCALE = 4;
	// About fifty bus accesses plus the interrupt wait with wide margin
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int IRQ_WAIT = 20 * TIMER_PRESCALE + 40;

	logic clock;
	logic i_rst_n;
	logic i_ibus_request;
	addr_t i_ibus_address;
	data_t o_ibus_rdata;
	logic o_ibus_ready;
	logic i_dbus_request;
	logic i_dbus_rw;
	addr_t i_dbus_address;
	data_t i_dbus_wdata;
	data_t o_dbus_rdata;
	logic o_dbus_ready;
	logic i_dma_request;
	logic i_dma_rw;
	addr_t i_dma_address;
	data_t i_dma_wdata;
	data_t o_dma_rdata;
	logic o_dma_ready;
	logic o_timer_irq;

	// Reference copy of the RAM contents
	data_t ref_mem [0:RAM_WORDS-1];
	int test_index [0:15];
	integer seed = 32'h22;
	int unsigned cycle_count = 0;
	int unsigned ibus_done;
	int unsigned dbus_done;
	int unsigned dma_done;

	tb_clock_gen #(
		.PERIOD_NS (100.0)
	) u_tb_clock_gen (
		.o_clock (clock)
	);

	soc_core #(
		.RAM_WORDS      (RAM_WORDS),
		.TIMER_PRESCALE (TIMER_PRESCALE)
	) u_soc_core (
		.clock          (clock),
		.i_rst_n        (i_rst_n),
		.i_ibus_request (i_ibus_request),
		.i_ibus_address (i_ibus_address),
		.o_ibus_rdata   (o_ibus_rdata),
		.o_ibus_ready   (o_ibus_ready),
		.i_dbus_request (i_dbus_request),
		.i_dbus_rw      (i_dbus_rw),
		.i_dbus_address (i_dbus_address),
		.i_dbus_wdata   (i_dbus_wdata),
		.o_dbus_rdata   (o_dbus_rdata),
		.o_dbus_ready   (o_dbus_ready),
		.i_dma_request  (i_dma_request),
		.i_dma_rw       (i_dma_rw),
		.i_dma_address  (i_dma_address),
		.i_dma_wdata    (i_dma_wdata),
		.o_dma_rdata    (o_dma_rdata),
		.o_dma_ready    (o_dma_ready),
		.o_timer_irq    (o_timer_irq)
	);

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	end

	function automatic addr_t ram_addr(input int index);
		return {REGION_RAM, 28'(index * 4)};
	endfunction

	function automatic addr_t timer_addr(input timer_reg_e sel);
		return {REGION_BRIDGE, PERIPH_TIMER, 20'h0, sel, 2'b00};
	endfunction

	task automatic expect_equal(input string test, input data_t expected, input data_t actual);
		assert (actual === expected) else begin
			$display("ERROR: %s expected %h actual %h", test, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// ==================================================
	// Master port drivers entered 1 ns after a rising edge
	task automatic ibus_read(input addr_t address, output data_t rdata);
		i_ibus_request = 1'b1;
		i_ibus_address = address;
		@(negedge clock);
		while (!o_ibus_ready)
			@(negedge clock);
		rdata = o_ibus_rdata;
		ibus_done = cycle_count;
		@(posedge clock);
		#1;
		i_ibus_request = 1'b0;
	endtask

	task automatic dbus_access(input logic rw, input addr_t address, input data_t wdata,
		output data_t rdata);
		i_dbus_request = 1'b1;
		i_dbus_rw = rw;
		i_dbus_address = address;
		i_dbus_wdata = wdata;
		@(negedge clock);
		while (!o_dbus_ready)
			@(negedge clock);
		rdata = o_dbus_rdata;
		dbus_done = cycle_count;
		@(posedge clock);
		#1;
		i_dbus_request = 1'b0;
	endtask

	task automatic dma_access(input logic rw, input addr_t address, input data_t wdata,
		output data_t rdata);
		i_dma_request = 1'b1;
		i_dma_rw = rw;
		i_dma_address = address;
		i_dma_wdata = wdata;
		@(negedge clock);
		while (!o_dma_ready)
			@(negedge clock);
		rdata = o_dma_rdata;
		dma_done = cycle_count;
		@(posedge clock);
		#1;
		i_dma_request = 1'b0;
	endtask

	// ==================================================
	// Directed tests
	task automatic reset_outputs_low();
		@(negedge clock);
		expect_equal("reset ibus ready", 32'd0, 32'(o_ibus_ready));
		expect_equal("reset dbus ready", 32'd0, 32'(o_dbus_ready));
		expect_equal("reset dma ready", 32'd0, 32'(o_dma_ready));
		expect_equal("reset timer irq", 32'd0, 32'(o_timer_irq));
		@(posedge clock);
		#1;
	endtask

	task automatic ram_write_readback();
		data_t rdata;
		for (int i = 0; i < 16; i++) begin
			test_index[i] = int'({$random(seed)} % RAM_WORDS);
			ref_mem[test_index[i]] = $random(seed);
			dbus_access(1'b1, ram_addr(test_index[i]), ref_mem[test_index[i]], rdata);
		end
		for (int i = 0; i < 16; i++) begin
			dbus_access(1'b0, ram_addr(test_index[i]), '0, rdata);
			expect_equal("ram readback", ref_mem[test_index[i]], rdata);
		end
	endtask

	task automatic fetch_and_dma_paths();
		data_t rdata;
		data_t value;
		for (int i = 0; i < 4; i++) begin
			ibus_read(ram_addr(test_index[i]), rdata);
			expect_equal("ibus fetch", ref_mem[test_index[i]], rdata);
		end
		value = $random(seed);
		ref_mem[512] = value;
		dma_access(1'b1, ram_addr(512), value, rdata);
		dbus_access(1'b0, ram_addr(512), '0, rdata);
		expect_equal("dma write dbus read", ref_mem[512], rdata);
	endtask

	task automatic three_port_contention();
		data_t ibus_data;
		data_t dbus_data;
		data_t dma_data;
		for (int i = 100; i < 103; i++) begin
			ref_mem[i] = $random(seed);
			dbus_access(1'b1, ram_addr(i), ref_mem[i], dbus_data);
		end
		fork
			ibus_read(ram_addr(100), ibus_data);
			dbus_access(1'b0, ram_addr(101), '0, dbus_data);
			dma_access(1'b0, ram_addr(102), '0, dma_data);
		join
		expect_equal("contention ibus", ref_mem[100], ibus_data);
		expect_equal("contention dbus", ref_mem[101], dbus_data);
		expect_equal("contention dma", ref_mem[102], dma_data);
		expect_true(dma_done < dbus_done && dma_done < ibus_done,
			"The DMA port did not complete first under contention");
		expect_true(dbus_done < ibus_done,
			"The data port did not complete before the instruction port");
	endtask

	task automatic timer_through_bridge();
		data_t rdata;
		int waited;
		dbus_access(1'b1, timer_addr(TIMER_COMPARE), 32'd20, rdata);
		dbus_access(1'b1, timer_addr(TIMER_CONTROL), 32'd1, rdata);
		waited = 0;
		while (!o_timer_irq && waited < IRQ_WAIT) begin
			@(negedge clock);
			waited++;
		end
		expect_true(o_timer_irq, "The timer interrupt did not rise within the wait limit");
		@(posedge clock);
		#1;
		dbus_access(1'b0, timer_addr(TIMER_COUNT), '0, rdata);
		expect_true(rdata >= 32'd20,
			$sformatf("ERROR: timer count expected at least 20 actual %0d", rdata));
		dbus_access(1'b0, timer_addr(TIMER_COMPARE), '0, rdata);
		expect_equal("timer compare readback", 32'd20, rdata);
		dbus_access(1'b1, timer_addr(TIMER_CONTROL), 32'd0, rdata);
		@(negedge clock);
		expect_equal("timer irq after disable", 32'd0, 32'(o_timer_irq));
		@(posedge clock);
		#1;
	endtask

	task automatic unmapped_accesses();
		data_t rdata;
		dbus_access(1'b0, 32'h3000_0010, '0, rdata);
		expect_equal("unmapped region read", 32'd0, rdata);
		// Offset of the compare register, which still holds a nonzero value
		dbus_access(1'b0, {REGION_BRIDGE, 4'h2, 24'h4}, '0, rdata);
		expect_equal("unmapped device read", 32'd0, rdata);
	endtask

	initial begin
		i_rst_n = 1'b0;
		i_ibus_request = 1'b0;
		i_ibus_address = '0;
		i_dbus_request = 1'b0;
		i_dbus_rw = 1'b0;
		i_dbus_address = '0;
		i_dbus_wdata = '0;
		i_dma_request = 1'b0;
		i_dma_rw = 1'b0;
		i_dma_address = '0;
		i_dma_wdata = '0;
		repeat (3) @(posedge clock);
		#1;
		i_rst_n = 1'b1;

		reset_outputs_low();
		ram_write_readback();
		fetch_and_dma_paths();
		three_port_contention();
		timer_through_bridge();
		unmapped_accesses();

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS = 100.0
) (
	output logic o_clock
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2.0) o_clock = ~o_clock;
	end

endmodule

`default_nettype wire

// ==== soc_core.f ====
common/soc_pkg.sv
common/soc_bus_if.sv
bus/bus_arbiter.sv
bus/addr_decoder.sv
verilog/sram_block.sv
bridge/periph_bridge.sv
bridge/timer_block.sv
verilog/soc_core.sv
sim/tb_clock_gen.sv
sim/soc_core_tb.sv

// ==== verilog/soc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_core #(
	parameter int RAM_WORDS = 1024,
	parameter int TIMER_PRESCALE = 4
) (
	input logic clock,
	input logic i_rst_n,

	input logic i_ibus_request,
	input soc_pkg::addr_t i_ibus_address,
	output soc_pkg::data_t o_ibus_rdata,
	output logic o_ibus_ready,

	input logic i_dbus_request,
	input logic i_dbus_rw,
	input soc_pkg::addr_t i_dbus_address,
	input soc_pkg::data_t i_dbus_wdata,
	output soc_pkg::data_t o_dbus_rdata,
	output logic o_dbus_ready,

	input logic i_dma_request,
	input logic i_dma_rw,
	input soc_pkg::addr_t i_dma_address,
	input soc_pkg::data_t i_dma_wdata,
	output soc_pkg::data_t o_dma_rdata,
	output logic o_dma_ready,

	output logic o_timer_irq
);

	soc_bus_if sys_bus ();
	soc_bus_if ram_bus ();
	soc_bus_if near_bus ();
	soc_bus_if far_bus ();

	// ==================================================
	// Main bus
	bus_arbiter u_bus_arbiter (
		.clock        (clock),
		.i_rst_n      (i_rst_n),
		.i_pa_request (i_ibus_request),
		.i_pa_address (i_ibus_address),
		.o_pa_rdata   (o_ibus_rdata),
		.o_pa_ready   (o_ibus_ready),
		.i_pb_request (i_dbus_request),
		.i_pb_rw      (i_dbus_rw),
		.i_pb_address (i_dbus_address),
		.i_pb_wdata   (i_dbus_wdata),
		.o_pb_rdata   (o_dbus_rdata),
		.o_pb_ready   (o_dbus_ready),
		.i_pc_request (i_dma_request),
		.i_pc_rw      (i_dma_rw),
		.i_pc_address (i_dma_address),
		.i_pc_wdata   (i_dma_wdata),
		.o_pc_rdata   (o_dma_rdata),
		.o_pc_ready   (o_dma_ready),
		.bus          (sys_bus)
	);

	addr_decoder u_addr_decoder (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.host    (sys_bus),
		.ram     (ram_bus),
		.near    (near_bus)
	);

	sram_block #(
		.RAM_WORDS (RAM_WORDS)
	) u_sram_block (
		.clock (clock),
		.bus   (ram_bus)
	);

	// ==================================================
	// Peripheral region behind the bridge
	periph_bridge u_periph_bridge (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.near    (near_bus),
		.far     (far_bus)
	);

	timer_block #(
		.TIMER_PRESCALE (TIMER_PRESCALE)
	) u_timer_block (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.bus     (far_bus),
		.o_irq   (o_timer_irq)
	);

endmodule

`default_nettype wire

// ==== verilog/sram_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_block #(
	parameter int RAM_WORDS = 1024
) (
	input logic clock,
	soc_bus_if.slave bus
);
	import soc_pkg::*;

	localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	data_t mem [0:RAM_WORDS-1];
	data_t rdata_q;
	logic ready_q;
	logic access;
	logic [IDX_W-1:0] index;

	// Word index wraps at the memory size
	assign index = IDX_W'(bus.address[31:2] % RAM_WORDS);

	// One pulse per access even when request is still high
	assign access = bus.request && !ready_q;

	always_ff @(posedge clock) begin
		ready_q <= access;
		if (access) begin
			if (bus.rw)
				mem[index] <= bus.wdata;
			rdata_q <= mem[index];
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.ready = ready_q;

endmodule

`default_nettype wire
